// File: design/aes_pkg.sv
/*
 * AES-256 shared definitions
 * State, block and key types, schedule sizes, round constants
 * and the round controller state encoding
 */
package aes_pkg;

    // Byte k sits at column k/4, row k%4, bits 8k+7..8k
    typedef logic [15:0][7:0] aes_state_t;

    // Block travelling in or out together with its strobe
    typedef struct packed {
        logic       valid;
        aes_state_t data;
    } aes_block_t;

    // Full cipher key, byte j at bits 8j+7..8j
    typedef logic [255:0] aes_key_t;

    // Same byte layout as the state so AddRoundKey is a plain XOR
    typedef logic [15:0][7:0] round_key_t;

    localparam int NUM_ROUNDS    = 14;
    localparam int NUM_KEY_WORDS = 60;

    // One constant per eighth schedule word, words 8 to 56
    localparam logic [7:0] RCON [7] = '{8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40};

    // Round controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADD_KEY,
        ST_LOAD,
        ST_SUB,
        ST_SHIFT,
        ST_MIX,
        ST_STORE,
        ST_DONE
    } enc_state_e;

endpackage

// File: design/aes_sbox.sv
/*
 * AES S-box for a single byte
 * Multiplicative inverse in GF(2^8) followed by the affine map,
 * purely combinational, no lookup table
 */
`timescale 1ns/1ps

module aes_sbox (
    input  logic [7:0] in_byte,
    output logic [7:0] out_byte
);

    logic [7:0] inv;
    logic [7:0] sq;

    // Product modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] t;
        p = 8'h00;
        t = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ t;
            // Multiply t by x and reduce
            t = {t[6:0], 1'b0} ^ (t[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Inverse as x^254 = x^2 * x^4 * ... * x^128
    // Zero falls out as zero, as the S-box definition wants
    always_comb
    begin
        sq  = in_byte;
        inv = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
    end

    // Affine map: b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
    assign out_byte = inv
                    ^ {inv[6:0], inv[7]}
                    ^ {inv[5:0], inv[7:6]}
                    ^ {inv[4:0], inv[7:5]}
                    ^ {inv[3:0], inv[7:4]}
                    ^ 8'h63;

endmodule

// File: design/aes_sub_shift.sv
/*
 * Byte-serial SubBytes with ShiftRows folded in
 * Unloads the state through one S-box, one byte per cycle, and
 * drops each result at its ShiftRows position
 */
`timescale 1ns/1ps

module aes_sub_shift (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  aes_pkg::aes_state_t state_in,
    output aes_pkg::aes_state_t state_out,
    output logic                sub_done
);
    import aes_pkg::*;

    aes_state_t shift_q;
    logic [3:0] byte_cnt;
    logic       active;
    logic [7:0] sub_byte;
    logic [1:0] row;
    logic [1:0] dst_col;
    logic [3:0] dst_idx;

    // Byte 0 of the shift register is always the one in the S-box
    aes_sbox i_sbox (
        .in_byte  (shift_q[0]),
        .out_byte (sub_byte)
    );

    // Row r moves left by r columns, wraps mod 4
    assign row     = byte_cnt[1:0];
    assign dst_col = byte_cnt[3:2] - row;
    assign dst_idx = {dst_col, row};

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            active   <= 1'b0;
            byte_cnt <= 4'd0;
            sub_done <= 1'b0;
        end
        else
        begin
            // Pulse once the sixteenth byte has been written
            sub_done <= active && (byte_cnt == 4'd15);
            if (start)
            begin
                active   <= 1'b1;
                byte_cnt <= 4'd0;
            end
            else if (active)
            begin
                byte_cnt <= byte_cnt + 4'd1;
                if (byte_cnt == 4'd15)
                    active <= 1'b0;
            end
        end
    end

    // Data path, shift down by one byte per cycle
    always_ff @(posedge clk)
    begin
        if (start)
            shift_q <= state_in;
        else if (active)
        begin
            shift_q            <= {8'h00, shift_q[15:1]};
            state_out[dst_idx] <= sub_byte;
        end
    end

endmodule

// File: design/aes_mix_columns.sv
/*
 * MixColumns stage
 * Multiplies each state column by the fixed AES matrix,
 * result registered every cycle
 */
`timescale 1ns/1ps

module aes_mix_columns (
    input  logic                clk,
    input  logic                resetn,
    input  aes_pkg::aes_state_t state_in,
    output aes_pkg::aes_state_t state_out
);

    // Multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // One column, rows 0..3 in bytes 0..3
    // 3a is xtime(a) ^ a
    function automatic logic [3:0][7:0] mix_col(input logic [3:0][7:0] a);
        logic [3:0][7:0] b;
        b[0] = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
        b[1] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
        b[2] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
        b[3] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        return b;
    endfunction

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state_out <= '0;
        else
        begin
            // Column c holds bytes 4c..4c+3
            for (int c = 0; c < 4; c++)
                state_out[4*c +: 4] <= mix_col(state_in[4*c +: 4]);
        end
    end

endmodule

// File: design/aes_key_expand.sv
/*
 * AES-256 key schedule
 * Loads the eight cipher key words, then derives words 8..59
 * one per cycle; round key r is read as words 4r..4r+3
 */
`timescale 1ns/1ps

module aes_key_expand (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 key_load,
    input  aes_pkg::aes_key_t    key_in,
    input  logic [3:0]           round_idx,
    output aes_pkg::round_key_t  round_key,
    output logic                 key_ready
);
    import aes_pkg::*;

    // Schedule memory, first byte of each word in bits 7:0
    logic [3:0][7:0] sched [NUM_KEY_WORDS];

    logic [5:0]      idx;
    logic            gen;
    logic [3:0][7:0] w_prev;
    logic [3:0][7:0] w_back;
    logic [3:0][7:0] sub_in;
    logic [3:0][7:0] sub_out;
    logic [3:0][7:0] w_new;
    logic [5:0]      rk_base;

    // w[i-1] and w[i-8], idx never drops below 8
    assign w_prev = sched[idx - 6'd1];
    assign w_back = sched[idx - 6'd8];

    // RotWord ahead of SubWord on every eighth word only
    assign sub_in = (idx[2] == 1'b0) ? {w_prev[0], w_prev[3:1]} : w_prev;

    // SubWord, one S-box per byte lane
    for (genvar b = 0; b < 4; b++)
    begin : g_subword
        aes_sbox i_sbox (
            .in_byte  (sub_in[b]),
            .out_byte (sub_out[b])
        );
    end

    always_comb
    begin
        case (idx[2:0])
            // Rcon goes into the first byte of the word
            3'd0:    w_new = w_back ^ sub_out ^ {24'h000000, RCON[idx[5:3] - 3'd1]};
            3'd4:    w_new = w_back ^ sub_out;
            default: w_new = w_back ^ w_prev;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            idx       <= 6'd8;
            gen       <= 1'b0;
            key_ready <= 1'b0;
        end
        else if (key_load)
        begin
            // Restart, old schedule is no longer valid
            idx       <= 6'd8;
            gen       <= 1'b1;
            key_ready <= 1'b0;
        end
        else if (gen)
        begin
            if (idx == 6'(NUM_KEY_WORDS))
            begin
                gen       <= 1'b0;
                key_ready <= 1'b1;
            end
            else
                idx <= idx + 6'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (key_load)
        begin
            for (int j = 0; j < 8; j++)
                sched[j] <= key_in[32*j +: 32];
        end
        else if (gen && (idx != 6'(NUM_KEY_WORDS)))
            sched[idx] <= w_new;
    end

    // Four consecutive words make one round key
    assign rk_base   = {round_idx, 2'b00};
    assign round_key = {sched[rk_base + 6'd3], sched[rk_base + 6'd2],
                        sched[rk_base + 6'd1], sched[rk_base]};

endmodule

// File: design/aes256_enc.sv
/*
 * AES-256 iterative encryption core
 * Round controller FSM, AddRoundKey register, input select and
 * output register around the serial S-box and MixColumns stages
 */
`timescale 1ns/1ps

module aes256_enc (
    input  logic                clk,
    input  logic                resetn,
    input  aes_pkg::aes_block_t blk_in,
    input  logic                key_ready,
    input  aes_pkg::round_key_t round_key,
    output logic [3:0]          round_idx,
    output logic                busy,
    output aes_pkg::aes_block_t blk_out
);
    import aes_pkg::*;

    enc_state_e state;
    enc_state_e state_next;
    logic [3:0] round;
    logic [3:0] sub_cnt;
    logic       accept;
    logic       start_sub;
    logic       sub_done;
    logic       out_valid;
    aes_state_t out_data;
    aes_state_t in_q;
    aes_state_t ark_q;
    aes_state_t loop_q;
    aes_state_t ark_src;
    aes_state_t shifted;
    aes_state_t mixed;

    // New block only with a valid schedule and nothing in flight
    assign accept    = blk_in.valid && key_ready && (state == ST_IDLE);
    assign busy      = (state != ST_IDLE);
    assign round_idx = round;
    assign start_sub = (state == ST_LOAD);

    // Plaintext for round 0, loop register afterwards
    assign ark_src = (round == 4'd0) ? in_q : loop_q;

    aes_sub_shift i_sub_shift (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start_sub),
        .state_in  (ark_q),
        .state_out (shifted),
        .sub_done  (sub_done)
    );

    // Sees the shifted state continuously, result one cycle later
    aes_mix_columns i_mix_columns (
        .clk       (clk),
        .resetn    (resetn),
        .state_in  (shifted),
        .state_out (mixed)
    );

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
                if (accept)
                    state_next = ST_ADD_KEY;
            // Key 14 closes the cipher
            ST_ADD_KEY:
                state_next = (round == 4'(NUM_ROUNDS)) ? ST_DONE : ST_LOAD;
            ST_LOAD:
                state_next = ST_SUB;
            // 16 bytes through the S-box
            ST_SUB:
                if (sub_cnt == 4'd15)
                    state_next = ST_SHIFT;
            // Last round has no MixColumns
            ST_SHIFT:
                if (sub_done)
                    state_next = (round == 4'(NUM_ROUNDS - 1)) ? ST_STORE : ST_MIX;
            ST_MIX:
                state_next = ST_STORE;
            ST_STORE:
                state_next = ST_ADD_KEY;
            ST_DONE:
                state_next = ST_IDLE;
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= ST_IDLE;
            round     <= 4'd0;
            sub_cnt   <= 4'd0;
            out_valid <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            out_valid <= (state == ST_DONE);
            if (accept)
                round <= 4'd0;
            else if (state == ST_STORE)
                round <= round + 4'd1;
            if (state == ST_SUB)
                sub_cnt <= sub_cnt + 4'd1;
            else
                sub_cnt <= 4'd0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            in_q <= blk_in.data;
        if (state == ST_ADD_KEY)
            ark_q <= ark_src ^ round_key;
        // End of round state for the next AddRoundKey
        if (state == ST_STORE)
            loop_q <= (round == 4'(NUM_ROUNDS - 1)) ? shifted : mixed;
        if (state == ST_DONE)
            out_data <= ark_q;
    end

    assign blk_out = '{valid: out_valid, data: out_data};

endmodule

// File: design/aes256_top.sv
/*
 * AES-256 encryption subsystem
 * Key schedule feeding the iterative encryption core
 */
`timescale 1ns/1ps

module aes256_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                key_load,
    input  aes_pkg::aes_key_t   key_in,
    input  aes_pkg::aes_block_t blk_in,
    output logic                key_ready,
    output logic                busy,
    output aes_pkg::aes_block_t blk_out
);
    import aes_pkg::*;

    round_key_t round_key;
    logic [3:0] round_idx;
    logic       key_load_ok;

    // Key cannot change under a block in flight
    assign key_load_ok = key_load && !busy;

    aes_key_expand i_aes_key_expand (
        .clk       (clk),
        .resetn    (resetn),
        .key_load  (key_load_ok),
        .key_in    (key_in),
        .round_idx (round_idx),
        .round_key (round_key),
        .key_ready (key_ready)
    );

    aes256_enc i_aes256_enc (
        .clk       (clk),
        .resetn    (resetn),
        .blk_in    (blk_in),
        .key_ready (key_ready),
        .round_key (round_key),
        .round_idx (round_idx),
        .busy      (busy),
        .blk_out   (blk_out)
    );

endmodule

// File: tests/aes_model.svh
/*
 * Behavioral AES-256 reference model for the testbench
 * S-box table, key schedule and block encryption, all on the
 * DUT byte layout with byte k in bits 8k+7..8k
 */
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// Built once at the start of simulation
logic [7:0] sbox_tab [256];

// Carry-less product first, then reduce by x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
    logic [15:0] p;
    p = 16'h0000;
    for (int i = 0; i < 8; i++)
        if (b[i])
            p = p ^ (16'(a) << i);
    for (int i = 15; i >= 8; i--)
        if (p[i])
            p = p ^ (16'h011b << (i - 8));
    return p[7:0];
endfunction

// Exhaustive search, zero maps to zero
function automatic logic [7:0] gf_inverse(input logic [7:0] a);
    logic [7:0] inv;
    inv = 8'h00;
    for (int y = 1; y < 256; y++)
        if (gf_mult(a, 8'(y)) == 8'h01)
            inv = 8'(y);
    return inv;
endfunction

// Bit form of the affine step from FIPS-197
function automatic logic [7:0] affine_map(input logic [7:0] b);
    logic [7:0] c;
    for (int i = 0; i < 8; i++)
        c[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8];
    return c ^ 8'h63;
endfunction

function automatic void fill_sbox_table();
    for (int x = 0; x < 256; x++)
        sbox_tab[x] = affine_map(gf_inverse(8'(x)));
endfunction

// Byte-wise table lookup on a whole word
function automatic logic [31:0] sub_word(input logic [31:0] w);
    logic [31:0] r;
    for (int b = 0; b < 4; b++)
        r[8*b +: 8] = sbox_tab[w[8*b +: 8]];
    return r;
endfunction

// Word i of the schedule in bits 32i+31..32i
function automatic logic [1919:0] expand_key(input logic [255:0] key);
    logic [31:0]   w [60];
    logic [31:0]   t;
    logic [7:0]    rc;
    logic [1919:0] ks;
    rc = 8'h01;
    for (int i = 0; i < 8; i++)
        w[i] = key[32*i +: 32];
    for (int i = 8; i < 60; i++)
    begin
        t = w[i - 1];
        if (i % 8 == 0)
        begin
            // RotWord moves byte 1 down to byte 0
            t  = sub_word({t[7:0], t[31:8]}) ^ {24'h000000, rc};
            rc = gf_mult(rc, 8'h02);
        end
        else if (i % 8 == 4)
            t = sub_word(t);
        w[i] = w[i - 8] ^ t;
    end
    for (int i = 0; i < 60; i++)
        ks[32*i +: 32] = w[i];
    return ks;
endfunction

// Fourteen rounds, state index 4c+r for column c, row r
function automatic logic [127:0] encrypt_block(input logic [255:0] key, input logic [127:0] pt);
    logic [1919:0] ks;
    logic [7:0]    s [16];
    logic [7:0]    t [16];
    logic [7:0]    a0;
    logic [7:0]    a1;
    logic [7:0]    a2;
    logic [7:0]    a3;
    logic [127:0]  ct;
    ks = expand_key(key);
    for (int k = 0; k < 16; k++)
        s[k] = pt[8*k +: 8] ^ ks[8*k +: 8];
    for (int rnd = 1; rnd <= 14; rnd++)
    begin
        // SubBytes with row r taken r columns further right
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                t[4*c + r] = sbox_tab[s[4*((c + r) % 4) + r]];
        for (int c = 0; c < 4; c++)
        begin
            a0 = t[4*c];
            a1 = t[4*c + 1];
            a2 = t[4*c + 2];
            a3 = t[4*c + 3];
            if (rnd < 14)
            begin
                s[4*c]     = gf_mult(a0, 8'h02) ^ gf_mult(a1, 8'h03) ^ a2 ^ a3;
                s[4*c + 1] = a0 ^ gf_mult(a1, 8'h02) ^ gf_mult(a2, 8'h03) ^ a3;
                s[4*c + 2] = a0 ^ a1 ^ gf_mult(a2, 8'h02) ^ gf_mult(a3, 8'h03);
                s[4*c + 3] = gf_mult(a0, 8'h03) ^ a1 ^ a2 ^ gf_mult(a3, 8'h02);
            end
            else
            begin
                // Final round, no MixColumns
                s[4*c]     = a0;
                s[4*c + 1] = a1;
                s[4*c + 2] = a2;
                s[4*c + 3] = a3;
            end
        end
        for (int k = 0; k < 16; k++)
            s[k] = s[k] ^ ks[128*rnd + 8*k +: 8];
    end
    for (int k = 0; k < 16; k++)
        ct[8*k +: 8] = s[k];
    return ct;
endfunction

`endif

// File: tests/aes256_tb.sv
/*
 * AES-256 subsystem testbench
 * Known-answer and random blocks against a behavioral model,
 * input gating on key_ready and busy, reset during a block
 */
`timescale 1ns/1ps

module aes256_tb;
    import aes_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int DRIVE_DELAY    = 1;
    localparam int NUM_RANDOM     = 20;
    localparam int BLOCKS_PER_KEY = 5;
    localparam int QUIET_CYCLES   = 500;
    // 26 blocks of about 300 cycles, 7 key loads of 53 cycles and
    // three quiet windows, with generous margin
    localparam int MAX_CYCLES     = 20000;

    logic       clk;
    logic       resetn;
    logic       key_load;
    aes_key_t   key_in;
    aes_block_t blk_in;
    logic       key_ready;
    logic       busy;
    aes_block_t blk_out;

    integer       seed;
    int           cycle_cnt = 0;
    int           out_cnt = 0;
    logic [127:0] last_out;
    logic [255:0] cur_key;

    `include "aes_model.svh"

    aes256_top i_aes256_top (
        .clk       (clk),
        .resetn    (resetn),
        .key_load  (key_load),
        .key_in    (key_in),
        .blk_in    (blk_in),
        .key_ready (key_ready),
        .busy      (busy),
        .blk_out   (blk_out)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("Timeout: the test did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Regression failed");
            $fatal(1, "watchdog expired");
        end
    end

    // Count result pulses and keep the data of the latest one
    always @(negedge clk)
    begin
        if (blk_out.valid === 1'b1)
        begin
            last_out = blk_out.data;
            out_cnt  = out_cnt + 1;
        end
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected)
        begin
            $display("** Error at time %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Published vectors list byte 0 first while the DUT holds it in bits 7:0
    function automatic logic [127:0] fips_block(input logic [127:0] v);
        logic [127:0] r;
        for (int k = 0; k < 16; k++)
            r[8*k +: 8] = v[8*(15 - k) +: 8];
        return r;
    endfunction

    function automatic logic [255:0] fips_key(input logic [255:0] v);
        logic [255:0] r;
        for (int k = 0; k < 32; k++)
            r[8*k +: 8] = v[8*(31 - k) +: 8];
        return r;
    endfunction

    function automatic logic [127:0] rand_block();
        logic [127:0] v;
        for (int j = 0; j < 4; j++)
            v[32*j +: 32] = $random(seed);
        return v;
    endfunction

    function automatic logic [255:0] rand_key();
        logic [255:0] v;
        for (int j = 0; j < 8; j++)
            v[32*j +: 32] = $random(seed);
        return v;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;
    endtask

    // One-cycle key_load pulse
    task automatic load_key(input logic [255:0] key);
        @(posedge clk);
        #DRIVE_DELAY;
        key_in   = key;
        key_load = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        key_load = 1'b0;
    endtask

    task automatic wait_key_ready();
        do
            @(negedge clk);
        while (key_ready !== 1'b1);
    endtask

    // One-cycle valid pulse with the plaintext
    task automatic send_block(input logic [127:0] pt);
        @(posedge clk);
        #DRIVE_DELAY;
        blk_in.data  = pt;
        blk_in.valid = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        blk_in.valid = 1'b0;
    endtask

    // Result count moves on the falling edge and is polled on the rising one
    task automatic wait_result(output logic [127:0] ct);
        int n;
        n = out_cnt;
        while (out_cnt == n)
            @(posedge clk);
        ct = last_out;
    endtask

    task automatic encrypt_and_check(input logic [127:0] pt);
        logic [127:0] ct;
        send_block(pt);
        wait_result(ct);
        check_value("blk_out.data", encrypt_block(cur_key, pt), ct);
    endtask

    // No result and busy low for the whole window
    task automatic expect_quiet(input int expected_cnt);
        repeat (QUIET_CYCLES)
        begin
            @(negedge clk);
            check_value("busy", 1'b0, busy);
        end
        check_value("blk_out.valid count", expected_cnt, out_cnt);
    endtask

    initial
    begin
        logic [127:0] pt;
        logic [127:0] ct;
        logic [127:0] kat_ct;
        int           n;
        seed     = 613;
        resetn   = 1'b0;
        key_load = 1'b0;
        key_in   = '0;
        blk_in   = '0;
        fill_sbox_table();
        apply_reset();
        check_value("model S-box of 53", 8'hed, sbox_tab[8'h53]);

        // Block with no key ever loaded
        n = out_cnt;
        send_block(rand_block());
        expect_quiet(n);

        // FIPS-197 appendix C.3
        cur_key = fips_key(256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f);
        pt      = fips_block(128'h00112233445566778899aabbccddeeff);
        kat_ct  = fips_block(128'h8ea2b7ca516745bfeafc49904b496089);
        check_value("model ciphertext", kat_ct, encrypt_block(cur_key, pt));
        load_key(cur_key);
        wait_key_ready();
        send_block(pt);
        wait_result(ct);
        check_value("blk_out.data", kat_ct, ct);

        // Random blocks with a fresh key every few blocks
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            if (i % BLOCKS_PER_KEY == 0)
            begin
                cur_key = rand_key();
                load_key(cur_key);
                wait_key_ready();
            end
            encrypt_and_check(rand_block());
        end

        // Block while the schedule is being rebuilt
        cur_key = rand_key();
        load_key(cur_key);
        n = out_cnt;
        send_block(rand_block());
        check_value("key_ready", 1'b0, key_ready);
        expect_quiet(n);
        check_value("key_ready", 1'b1, key_ready);
        encrypt_and_check(rand_block());

        // Second block during a running one must be dropped
        n  = out_cnt;
        pt = rand_block();
        send_block(pt);
        check_value("busy", 1'b1, busy);
        repeat (20) @(posedge clk);
        send_block(rand_block());
        wait_result(ct);
        check_value("blk_out.data", encrypt_block(cur_key, pt), ct);
        expect_quiet(n + 1);

        // Reset partway through a block
        send_block(rand_block());
        repeat (100) @(posedge clk);
        #DRIVE_DELAY;
        check_value("busy", 1'b1, busy);
        n = out_cnt;
        apply_reset();
        check_value("key_ready", 1'b0, key_ready);
        check_value("busy", 1'b0, busy);
        check_value("blk_out.valid", 1'b0, blk_out.valid);
        load_key(cur_key);
        wait_key_ready();
        encrypt_and_check(rand_block());
        check_value("blk_out.valid count", n + 1, out_cnt);

        $display("Regression passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+tests
design/aes_pkg.sv
design/aes_sbox.sv
design/aes_sub_shift.sv
design/aes_mix_columns.sv
design/aes_key_expand.sv
design/aes256_enc.sv
design/aes256_top.sv
tests/aes256_tb.sv

// File: Bender.yml
package:
  name: aes256

sources:
  # Design, package first
  - design/aes_pkg.sv
  - design/aes_sbox.sv
  - design/aes_sub_shift.sv
  - design/aes_mix_columns.sv
  - design/aes_key_expand.sv
  - design/aes256_enc.sv
  - design/aes256_top.sv
  # Testbench with the model header folder
  - target: test
    include_dirs:
      - tests
    files:
      - tests/aes256_tb.sv
